//--- rtl/priv_params.svh
// Widths and reset values for the machine-mode trap unit
// The mtimecmp addresses sit in the custom machine read/write range
`ifndef PRIV_PARAMS_SVH
`define PRIV_PARAMS_SVH

`define PRIV_XLEN           32
`define PRIV_TIMER_DIV      4                // CLK cycles per mtime tick
`define PRIV_RESET_MTVEC    32'h0000_0100    // Direct mode, word aligned

`define PRIV_CSR_MSTATUS    12'h300
`define PRIV_CSR_MIE        12'h304
`define PRIV_CSR_MTVEC      12'h305
`define PRIV_CSR_MEPC       12'h341
`define PRIV_CSR_MCAUSE     12'h342
`define PRIV_CSR_MTVAL      12'h343
`define PRIV_CSR_MIP        12'h344
`define PRIV_CSR_MTIMECMP_L 12'h7C0
`define PRIV_CSR_MTIMECMP_H 12'h7C1

`endif

//--- rtl/priv_types_pkg.sv
// Shared types of the trap unit, M and U modes only
// Reserved fields of the CSR layouts always hold zero
`include "priv_params.svh"

package priv_types_pkg;

    typedef enum logic [3:0] {
        INSN_MAL     = 4'd0,
        INSN_ACCESS  = 4'd1,
        ILLEGAL_INSN = 4'd2,
        BREAKPOINT   = 4'd3,
        L_ADDR_MAL   = 4'd4,
        L_FAULT      = 4'd5,
        S_ADDR_MAL   = 4'd6,
        S_FAULT      = 4'd7,
        ENV_CALL_U   = 4'd8,
        ENV_CALL_M   = 4'd11
    } ex_code_t;

    typedef enum logic [3:0] {
        SOFT_INT_M  = 4'd3,
        TIMER_INT_M = 4'd7,
        EXT_INT_M   = 4'd11
    } int_code_t;

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_level_t;

    typedef enum logic [1:0] {IDLE, FLUSH, COMMIT, RETURN} trap_state_t;

    typedef enum logic [11:0] {
        CSR_MSTATUS    = `PRIV_CSR_MSTATUS,
        CSR_MIE        = `PRIV_CSR_MIE,
        CSR_MTVEC      = `PRIV_CSR_MTVEC,
        CSR_MEPC       = `PRIV_CSR_MEPC,
        CSR_MCAUSE     = `PRIV_CSR_MCAUSE,
        CSR_MTVAL      = `PRIV_CSR_MTVAL,
        CSR_MIP        = `PRIV_CSR_MIP,
        CSR_MTIMECMP_L = `PRIV_CSR_MTIMECMP_L,
        CSR_MTIMECMP_H = `PRIV_CSR_MTIMECMP_H
    } csr_addr_t;

    // Field order is the exception priority, highest first
    typedef struct packed {
        logic breakpoint;
        logic fault_insn_access;
        logic illegal_insn;
        logic mal_insn;
        logic env_u;
        logic env_m;
        logic mal_s;
        logic mal_l;
        logic fault_s;
        logic fault_l;
    } ex_req_t;

    typedef struct packed {
        logic [31:13] rsvd_hi;
        priv_level_t  mpp;       // bits 12:11
        logic [10:8]  rsvd_mid;
        logic         mpie;      // bit 7
        logic [6:4]   rsvd_lo;
        logic         mie;       // bit 3
        logic [2:0]   rsvd_base;
    } mstatus_t;

    // Layout shared by mie and mip, enable bits sit under the pending names
    typedef struct packed {
        logic [31:12] rsvd_hi;
        logic         meip;      // bit 11
        logic [10:8]  rsvd_mid;
        logic         mtip;      // bit 7
        logic [6:4]   rsvd_lo;
        logic         msip;      // bit 3
        logic [2:0]   rsvd_base;
    } irq_bits_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] cause;
    } mcause_t;

    typedef struct packed {
        mcause_t                mcause;
        logic [`PRIV_XLEN-1:0]  mepc;
        logic [`PRIV_XLEN-1:0]  mtval;
        mstatus_t               mstatus;
    } trap_info_t;

endpackage

//--- rtl/priv_int_ex_handler.sv
// Purely combinational, its outputs are only used on a commit
// Interrupts are judged on the registered mip, so a new line shows one cycle late
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_int_ex_handler (
    input  priv_types_pkg::ex_req_t     ex_req,
    input  logic [`PRIV_XLEN-1:0]       epc,
    input  logic [`PRIV_XLEN-1:0]       bad_addr,
    input  logic                        ext_int,
    input  logic                        timer_int,
    input  priv_types_pkg::mstatus_t    curr_mstatus,
    input  priv_types_pkg::irq_bits_t   curr_mie,
    input  priv_types_pkg::irq_bits_t   curr_mip,
    input  priv_types_pkg::priv_level_t priv_level,
    output logic                        intr,
    output priv_types_pkg::trap_info_t  trap_info,
    output priv_types_pkg::irq_bits_t   next_mip
);

    import priv_types_pkg::*;

    ex_code_t  ex_src;
    logic      exception;
    logic      tval_addr;      // Cause records the faulting address
    int_code_t int_src;
    logic      interrupt;
    irq_bits_t int_active;

    // Exception pick, first field of ex_req wins
    always_comb begin
        exception = 1'b1;
        ex_src    = INSN_MAL;
        tval_addr = 1'b0;
        if (ex_req.breakpoint) begin
            ex_src = BREAKPOINT;
        end else if (ex_req.fault_insn_access) begin
            ex_src    = INSN_ACCESS;
            tval_addr = 1'b1;
        end else if (ex_req.illegal_insn) begin
            ex_src = ILLEGAL_INSN;
        end else if (ex_req.mal_insn) begin
            ex_src    = INSN_MAL;
            tval_addr = 1'b1;
        end else if (ex_req.env_u) begin
            ex_src = ENV_CALL_U;
        end else if (ex_req.env_m) begin
            ex_src = ENV_CALL_M;
        end else if (ex_req.mal_s) begin
            ex_src    = S_ADDR_MAL;
            tval_addr = 1'b1;
        end else if (ex_req.mal_l) begin
            ex_src    = L_ADDR_MAL;
            tval_addr = 1'b1;
        end else if (ex_req.fault_s) begin
            ex_src    = S_FAULT;
            tval_addr = 1'b1;
        end else if (ex_req.fault_l) begin
            ex_src    = L_FAULT;
            tval_addr = 1'b1;
        end else begin
            exception = 1'b0;
        end
    end

    assign int_active = curr_mie & curr_mip;

    // Enabled interrupts only, external before software before timer
    always_comb begin
        interrupt = curr_mstatus.mie;
        int_src   = SOFT_INT_M;
        if (int_active.meip)      int_src = EXT_INT_M;
        else if (int_active.msip) int_src = SOFT_INT_M;
        else if (int_active.mtip) int_src = TIMER_INT_M;
        else                      interrupt = 1'b0;
    end

    assign intr = exception | interrupt;

    always_comb begin
        trap_info.mcause.interrupt = ~exception;
        trap_info.mcause.cause     = exception ? 31'(ex_src) : 31'(int_src);
        trap_info.mepc             = epc;
        trap_info.mtval            = (exception && tval_addr) ? bad_addr : '0;

        trap_info.mstatus      = curr_mstatus;
        trap_info.mstatus.mpie = curr_mstatus.mie;
        trap_info.mstatus.mie  = 1'b0;
        trap_info.mstatus.mpp  = priv_level;   // Mode the trap came from
    end

    // Hardware lines track the inputs, msip is kept for software
    always_comb begin
        next_mip      = curr_mip;
        next_mip.meip = ext_int;
        next_mip.mtip = timer_int;
    end

endmodule

//--- rtl/priv_trap_fsm.sv
// Trap sequencer, a pending trap always beats an mret sampled in the same cycle
// The pipeline must hold its request until trap_taken
`timescale 1ns/1ps

module priv_trap_fsm (
    input  logic CLK,
    input  logic rst_n,
    input  logic intr,
    input  logic mret,
    input  logic pipe_clear,
    input  logic ex_mem_stall,
    output logic flush,
    output logic trap_taken,
    output logic mret_taken,
    output logic commit_trap,
    output logic commit_ret
);

    import priv_types_pkg::*;

    trap_state_t state, next_state;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (intr)      next_state = FLUSH;
                else if (mret) next_state = RETURN;
            end
            FLUSH: begin
                // Wait for an empty pipe with no memory access in flight
                if (pipe_clear && !ex_mem_stall) next_state = COMMIT;
            end
            COMMIT:  next_state = IDLE;
            RETURN:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign flush       = (state == FLUSH);
    assign commit_trap = (state == COMMIT);
    assign trap_taken  = (state == COMMIT);
    assign commit_ret  = (state == RETURN);
    assign mret_taken  = (state == RETURN);

endmodule

//--- rtl/priv_timer.sv
// Machine timer, mtime itself is not visible on the CSR port
// mtimecmp halves are written separately, so a split update can fire early
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_timer (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      csr_we,
    input  priv_types_pkg::csr_addr_t csr_addr,
    input  logic [`PRIV_XLEN-1:0]     csr_wdata,
    output logic                      timer_int
);

    import priv_types_pkg::*;

    localparam int PRESC_W = (`PRIV_TIMER_DIV > 1) ? $clog2(`PRIV_TIMER_DIV) : 1;

    logic [PRESC_W-1:0] presc;
    logic [63:0]        mtime;
    logic [63:0]        mtimecmp;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            presc <= '0;
            mtime <= '0;
        end else if (presc == PRESC_W'(`PRIV_TIMER_DIV - 1)) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mtimecmp <= '1;        // No timer interrupt out of reset
        end else if (csr_we) begin
            if (csr_addr == CSR_MTIMECMP_L) mtimecmp[31:0]  <= csr_wdata;
            if (csr_addr == CSR_MTIMECMP_H) mtimecmp[63:32] <= csr_wdata;
        end
    end

    assign timer_int = (mtime >= mtimecmp);

endmodule

//--- rtl/priv_csr_file.sv
// Machine CSRs for M and U modes, direct mtvec only
// A commit in the same cycle as a CSR write drops the write
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_csr_file (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  logic                        csr_we,
    input  priv_types_pkg::csr_addr_t   csr_addr,
    input  logic [`PRIV_XLEN-1:0]       csr_wdata,
    output logic [`PRIV_XLEN-1:0]       csr_rdata,
    input  logic                        commit_trap,
    input  logic                        commit_ret,
    input  priv_types_pkg::trap_info_t  trap_info,
    input  priv_types_pkg::irq_bits_t   next_mip,
    output priv_types_pkg::mstatus_t    curr_mstatus,
    output priv_types_pkg::irq_bits_t   curr_mie,
    output priv_types_pkg::irq_bits_t   curr_mip,
    output priv_types_pkg::priv_level_t priv_level,
    output logic [`PRIV_XLEN-1:0]       mtvec,
    output logic [`PRIV_XLEN-1:0]       mepc
);

    import priv_types_pkg::*;

    mcause_t               mcause;
    logic [`PRIV_XLEN-1:0] mtval;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            curr_mstatus <= '0;
            curr_mie     <= '0;
            curr_mip     <= '0;
            mtvec        <= `PRIV_RESET_MTVEC;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            priv_level   <= M_MODE;
        end else begin
            curr_mip <= next_mip;              // Interrupt lines land every cycle
            if (commit_trap) begin
                curr_mstatus <= trap_info.mstatus;
                mcause       <= trap_info.mcause;
                mepc         <= trap_info.mepc;
                mtval        <= trap_info.mtval;
                priv_level   <= M_MODE;
            end else if (commit_ret) begin
                curr_mstatus.mie  <= curr_mstatus.mpie;
                curr_mstatus.mpie <= 1'b1;
                curr_mstatus.mpp  <= U_MODE;
                priv_level        <= curr_mstatus.mpp;
            end else if (csr_we) begin
                case (csr_addr)
                    CSR_MSTATUS: begin
                        curr_mstatus.mie  <= csr_wdata[3];
                        curr_mstatus.mpie <= csr_wdata[7];
                        // Only U and M exist, anything else reads back as U
                        curr_mstatus.mpp  <= (csr_wdata[12:11] == 2'b11) ? M_MODE : U_MODE;
                    end
                    CSR_MIE: begin
                        curr_mie.msip <= csr_wdata[3];
                        curr_mie.mtip <= csr_wdata[7];
                        curr_mie.meip <= csr_wdata[11];
                    end
                    CSR_MIP:    curr_mip.msip <= csr_wdata[3];
                    CSR_MTVEC:  mtvec  <= {csr_wdata[`PRIV_XLEN-1:2], 2'b00};
                    CSR_MEPC:   mepc   <= {csr_wdata[`PRIV_XLEN-1:2], 2'b00};
                    CSR_MCAUSE: mcause <= csr_wdata;
                    CSR_MTVAL:  mtval  <= csr_wdata;
                    default: ;                 // mtimecmp lives in the timer
                endcase
            end
        end
    end

    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = curr_mstatus;
            CSR_MIE:     csr_rdata = curr_mie;
            CSR_MIP:     csr_rdata = curr_mip;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            CSR_MTVAL:   csr_rdata = mtval;
            default:     csr_rdata = '0;
        endcase
    end

endmodule

//--- rtl/priv_unit.sv
// Machine-mode trap unit, trap_vector is the raw mtvec in direct mode
// ex_req is held by the pipeline until trap_taken
`timescale 1ns/1ps
`include "priv_params.svh"

module priv_unit (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  priv_types_pkg::ex_req_t     ex_req,
    input  logic [`PRIV_XLEN-1:0]       epc,
    input  logic [`PRIV_XLEN-1:0]       bad_addr,
    input  logic                        mret,
    input  logic                        pipe_clear,
    input  logic                        ex_mem_stall,
    input  logic                        ext_int,
    input  logic                        csr_we,
    input  priv_types_pkg::csr_addr_t   csr_addr,
    input  logic [`PRIV_XLEN-1:0]       csr_wdata,
    output logic [`PRIV_XLEN-1:0]       csr_rdata,
    output logic                        flush,
    output logic                        trap_taken,
    output logic                        mret_taken,
    output logic [`PRIV_XLEN-1:0]       trap_vector,
    output logic [`PRIV_XLEN-1:0]       ret_target,
    output priv_types_pkg::priv_level_t priv_level
);

    import priv_types_pkg::*;

    logic       timer_int;
    logic       intr;
    logic       commit_trap, commit_ret;
    trap_info_t trap_info;
    irq_bits_t  next_mip, curr_mie, curr_mip;
    mstatus_t   curr_mstatus;

    priv_int_ex_handler priv_int_ex_handler_inst (
        .ex_req       (ex_req),
        .epc          (epc),
        .bad_addr     (bad_addr),
        .ext_int      (ext_int),
        .timer_int    (timer_int),
        .curr_mstatus (curr_mstatus),
        .curr_mie     (curr_mie),
        .curr_mip     (curr_mip),
        .priv_level   (priv_level),
        .intr         (intr),
        .trap_info    (trap_info),
        .next_mip     (next_mip)
    );

    priv_trap_fsm priv_trap_fsm_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .intr         (intr),
        .mret         (mret),
        .pipe_clear   (pipe_clear),
        .ex_mem_stall (ex_mem_stall),
        .flush        (flush),
        .trap_taken   (trap_taken),
        .mret_taken   (mret_taken),
        .commit_trap  (commit_trap),
        .commit_ret   (commit_ret)
    );

    priv_timer priv_timer_inst (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .timer_int (timer_int)
    );

    priv_csr_file priv_csr_file_inst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .commit_trap  (commit_trap),
        .commit_ret   (commit_ret),
        .trap_info    (trap_info),
        .next_mip     (next_mip),
        .curr_mstatus (curr_mstatus),
        .curr_mie     (curr_mie),
        .curr_mip     (curr_mip),
        .priv_level   (priv_level),
        .mtvec        (trap_vector),
        .mepc         (ret_target)
    );

endmodule

//--- verification/tb_clock_gen.sv
// Free-running testbench clock, starts low at time zero
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

//--- verification/priv_unit_sva.sv
// Output protocol checks bound into every priv_unit instance
// All checks are off while rst_n is low
`timescale 1ns/1ps

module priv_unit_sva (
    input logic CLK,
    input logic rst_n,
    input logic flush,
    input logic trap_taken,
    input logic mret_taken
);

    a_no_overlap: assert property (@(posedge CLK) disable iff (!rst_n)
        !(trap_taken && mret_taken))
        else $error("trap_taken and mret_taken are high in the same cycle");

    a_trap_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
        trap_taken |=> !trap_taken)
        else $error("trap_taken is high for more than one cycle");

    // The flush ends once the trap is committed
    a_flush_drops: assert property (@(posedge CLK) disable iff (!rst_n)
        trap_taken |=> !flush)
        else $error("flush is still high in the cycle after trap_taken");

endmodule

bind priv_unit priv_unit_sva priv_unit_sva_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .flush      (flush),
    .trap_taken (trap_taken),
    .mret_taken (mret_taken)
);

//--- verification/tb_priv_unit.sv
// Directed tests for priv_unit with inputs changed on the rising edge
// Outputs and CSR reads are sampled on the falling edge
`timescale 1ns/1ps
`include "priv_params.svh"

module tb_priv_unit;

    import priv_types_pkg::*;

    localparam int WAIT_LIMIT = 40;    // Cycles before a wait gives up

    // Exception cause and mtval source per ex_req field in priority order
    localparam ex_code_t EX_CODE [10] = '{BREAKPOINT, INSN_ACCESS, ILLEGAL_INSN, INSN_MAL,
                                          ENV_CALL_U, ENV_CALL_M, S_ADDR_MAL, L_ADDR_MAL,
                                          S_FAULT, L_FAULT};
    localparam logic [9:0] TVAL_ADDR = 10'b11_1100_1010;

    logic                  CLK;
    logic                  rst_n;
    ex_req_t               ex_req;
    logic [`PRIV_XLEN-1:0] epc;
    logic [`PRIV_XLEN-1:0] bad_addr;
    logic                  mret;
    logic                  pipe_clear;
    logic                  ex_mem_stall;
    logic                  ext_int;
    logic                  csr_we;
    csr_addr_t             csr_addr;
    logic [`PRIV_XLEN-1:0] csr_wdata;
    logic [`PRIV_XLEN-1:0] csr_rdata;
    logic                  flush;
    logic                  trap_taken;
    logic                  mret_taken;
    logic [`PRIV_XLEN-1:0] trap_vector;
    logic [`PRIV_XLEN-1:0] ret_target;
    priv_level_t           priv_level;

    int          value_errors;
    int          timeout_errors;
    int          protocol_errors;
    logic        trap_seen;
    logic [31:0] exp_mtvec;

    tb_clock_gen #(.period_ns(100)) tb_clock_gen_inst (.clk(CLK));

    priv_unit priv_unit_inst (.*);

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
        @(posedge CLK);
        csr_we    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge CLK);
        csr_we <= 1'b0;                    // Write has landed at this edge
    endtask

    task automatic csr_read(input csr_addr_t addr, output logic [31:0] data);
        @(posedge CLK);
        csr_addr <= addr;
        @(negedge CLK);
        data = csr_rdata;
    endtask

    // Counts edges from the request edge up to trap_taken
    task automatic wait_trap(output int cycles);
        cycles = 0;
        @(negedge CLK);
        while (!trap_taken && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            cycles++;
            @(negedge CLK);
        end
        if (!trap_taken) begin
            timeout_errors++;
            $display("Timeout at %0t ns: no trap_taken within %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    // Expects no trap and a steady flush level for n cycles and returns on a rising edge
    task automatic watch_cycles(input int n, input logic want_flush);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK);
            if (flush !== want_flush || trap_taken !== 1'b0) begin
                value_errors++;
                $display("ERROR at %0t ns: flush %b trap_taken %b, expected flush %b and no trap",
                         $time, flush, trap_taken, want_flush);
            end
            @(posedge CLK);
        end
    endtask

    // mret_taken must follow one cycle after a single-cycle strobe
    task automatic issue_mret(output logic [31:0] target);
        @(posedge CLK);
        mret <= 1'b1;
        @(negedge CLK);
        compare_word("mret_taken in strobe cycle", {31'd0, mret_taken}, 32'd0);
        @(posedge CLK);
        mret <= 1'b0;
        @(negedge CLK);
        compare_word("mret_taken after strobe", {31'd0, mret_taken}, 32'd1);
        target = ret_target;
    endtask

    task automatic timer_off();
        csr_write(CSR_MTIMECMP_H, 32'hFFFF_FFFF);
        csr_write(CSR_MTIMECMP_L, 32'hFFFF_FFFF);
    endtask

    task automatic test_exception_priority();
        int          a;
        int          b;
        int          hi;
        int          cycles;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] rd;
        logic [9:0]  req;
        for (int n = 0; n < 12; n++) begin
            a    = $urandom_range(9, 0);
            b    = (a + 1 + int'($urandom_range(8, 0))) % 10;   // Always differs from a
            hi   = (a < b) ? a : b;
            pc   = $urandom;
            addr = $urandom;
            req  = '0;
            req[9 - a] = 1'b1;
            req[9 - b] = 1'b1;
            @(posedge CLK);
            ex_req   <= ex_req_t'(req);
            epc      <= pc;
            bad_addr <= addr;
            wait_trap(cycles);
            compare_word("trap latency", 32'(cycles), 32'd2);
            compare_word("trap_vector", trap_vector, exp_mtvec);
            @(posedge CLK);
            ex_req <= '0;
            csr_read(CSR_MCAUSE, rd);
            compare_word("mcause", rd, {28'd0, EX_CODE[hi]});
            csr_read(CSR_MEPC, rd);
            compare_word("mepc", rd, pc);
            csr_read(CSR_MTVAL, rd);
            compare_word("mtval", rd, TVAL_ADDR[hi] ? addr : 32'd0);
        end
    endtask

    task automatic test_interrupt_gating();
        logic [31:0] rd;
        int          cycles;
        csr_write(CSR_MTIMECMP_L, 32'd0);
        csr_write(CSR_MTIMECMP_H, 32'd0);     // Timer fires from here on
        watch_cycles(6, 1'b0);
        csr_read(CSR_MIP, rd);
        compare_word("mip.mtip", {31'd0, rd[7]}, 32'd1);
        csr_write(CSR_MIE, 32'h0000_0080);    // mtie only with the global enable still off
        watch_cycles(6, 1'b0);
        csr_write(CSR_MIE, 32'h0);
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        watch_cycles(6, 1'b0);
        csr_write(CSR_MIE, 32'h0000_0080);
        wait_trap(cycles);
        csr_read(CSR_MCAUSE, rd);
        compare_word("timer mcause", rd, 32'h8000_0007);
        timer_off();
    endtask

    task automatic test_cross_priority();
        logic [31:0] rd;
        logic [31:0] pc;
        int          cycles;
        csr_write(CSR_MTIMECMP_L, 32'd0);
        csr_write(CSR_MTIMECMP_H, 32'd0);
        csr_write(CSR_MIP, 32'h0000_0008);    // Software interrupt pending
        @(posedge CLK);
        ext_int <= 1'b1;
        csr_write(CSR_MIE, 32'h0000_0888);
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        wait_trap(cycles);
        csr_read(CSR_MCAUSE, rd);
        compare_word("mcause with all pending", rd, 32'h8000_000B);

        // Interrupt starts the flush and an exception joins before the commit
        pc = $urandom;
        @(posedge CLK);
        pipe_clear <= 1'b0;
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        @(posedge CLK);
        ex_req   <= ex_req_t'(10'b00_1000_0000);   // illegal_insn
        epc      <= pc;
        bad_addr <= $urandom;
        @(posedge CLK);
        pipe_clear <= 1'b1;
        wait_trap(cycles);
        @(posedge CLK);
        ex_req <= '0;
        csr_read(CSR_MCAUSE, rd);
        compare_word("mcause exception over interrupt", rd, 32'h0000_0002);
        csr_read(CSR_MEPC, rd);
        compare_word("mepc exception over interrupt", rd, pc);
        csr_read(CSR_MTVAL, rd);
        compare_word("mtval illegal instruction", rd, 32'd0);

        @(posedge CLK);
        ext_int <= 1'b0;
        csr_write(CSR_MIP, 32'h0);
        csr_write(CSR_MIE, 32'h0);
        timer_off();
    endtask

    task automatic test_trap_return();
        logic [31:0] rd;
        logic [31:0] pc;
        logic [31:0] target;
        int          cycles;
        csr_write(CSR_MSTATUS, 32'h0000_0080);    // mpie set with mpp U
        issue_mret(target);
        csr_read(CSR_MSTATUS, rd);
        compare_word("mstatus in U mode", rd, 32'h0000_0088);
        compare_word("priv_level after first mret", {30'd0, priv_level}, 32'd0);

        pc = $urandom;
        @(posedge CLK);
        ex_req <= ex_req_t'(10'b00_0010_0000);     // env_u
        epc    <= pc;
        wait_trap(cycles);
        @(posedge CLK);
        ex_req <= '0;
        csr_read(CSR_MSTATUS, rd);
        compare_word("mstatus after trap", rd, 32'h0000_0080);
        compare_word("priv_level after trap", {30'd0, priv_level}, 32'd3);
        csr_read(CSR_MCAUSE, rd);
        compare_word("mcause env_u", rd, 32'h0000_0008);

        issue_mret(target);
        compare_word("ret_target", target, pc);
        csr_read(CSR_MSTATUS, rd);
        compare_word("mstatus after mret", rd, 32'h0000_0088);
        compare_word("priv_level after mret", {30'd0, priv_level}, 32'd0);
    endtask

    task automatic test_back_pressure();
        logic [31:0] rd;
        logic [31:0] addr;
        int          cycles;
        addr = $urandom;
        @(posedge CLK);
        pipe_clear   <= 1'b0;                          // Pipeline still draining
        ex_req       <= ex_req_t'(10'b00_0000_0100);   // mal_l
        epc          <= $urandom;
        bad_addr     <= addr;
        @(posedge CLK);                                // FSM enters FLUSH here
        watch_cycles(5, 1'b1);
        pipe_clear   <= 1'b1;
        ex_mem_stall <= 1'b1;                          // Memory access still in flight
        watch_cycles(4, 1'b1);
        ex_mem_stall <= 1'b0;
        wait_trap(cycles);
        compare_word("latency after release", 32'(cycles), 32'd1);
        @(posedge CLK);
        ex_req <= '0;
        csr_read(CSR_MCAUSE, rd);
        compare_word("mcause load misaligned", rd, 32'h0000_0004);
        csr_read(CSR_MTVAL, rd);
        compare_word("mtval load misaligned", rd, addr);
    endtask

    task automatic test_csr_round_trip();
        logic [31:0] v;
        logic [31:0] rd;
        csr_write(CSR_MSTATUS, 32'h0);             // Keep interrupts off
        for (int n = 0; n < 4; n++) begin
            v = $urandom;
            csr_write(CSR_MTVEC, v);
            exp_mtvec = v & 32'hFFFF_FFFC;
            csr_read(CSR_MTVEC, rd);
            compare_word("mtvec read", rd, exp_mtvec);
            compare_word("trap_vector", trap_vector, exp_mtvec);
            v = $urandom;
            csr_write(CSR_MEPC, v);
            csr_read(CSR_MEPC, rd);
            compare_word("mepc read", rd, v & 32'hFFFF_FFFC);
            v = $urandom;
            csr_write(CSR_MIE, v);
            csr_read(CSR_MIE, rd);
            compare_word("mie read", rd, v & 32'h0000_0888);
        end
        csr_write(CSR_MIE, 32'h0);
    endtask

    // Output protocol watch sampled once per cycle
    always @(negedge CLK) begin
        if (rst_n && trap_taken && mret_taken) begin
            protocol_errors++;
            $display("ERROR at %0t ns: trap_taken and mret_taken together", $time);
        end
        if (rst_n && trap_seen && (trap_taken || flush)) begin
            protocol_errors++;
            $display("ERROR at %0t ns: trap_taken or flush high after trap_taken", $time);
        end
        trap_seen = rst_n && trap_taken;
    end

    initial begin
        void'($urandom(3));
        value_errors    = 0;
        timeout_errors  = 0;
        protocol_errors = 0;
        trap_seen       = 1'b0;
        exp_mtvec       = `PRIV_RESET_MTVEC;
        rst_n           = 1'b0;
        ex_req          = '0;
        epc             = '0;
        bad_addr        = '0;
        mret            = 1'b0;
        pipe_clear      = 1'b1;
        ex_mem_stall    = 1'b0;
        ext_int         = 1'b0;
        csr_we          = 1'b0;
        csr_addr        = CSR_MSTATUS;
        csr_wdata       = '0;
        repeat (5) @(posedge CLK);
        rst_n <= 1'b1;

        test_exception_priority();
        test_interrupt_gating();
        test_cross_priority();
        test_trap_return();
        test_back_pressure();
        test_csr_round_trip();

        @(posedge CLK);
        $display("Summary: %0d value errors, %0d timeouts, %0d protocol errors",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors == 0 && timeout_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/priv_types_pkg.sv
rtl/priv_int_ex_handler.sv
rtl/priv_trap_fsm.sv
rtl/priv_timer.sv
rtl/priv_csr_file.sv
rtl/priv_unit.sv
verification/tb_clock_gen.sv
verification/priv_unit_sva.sv
verification/tb_priv_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = tb_priv_unit
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
FAIL_MSG  = Some tests failed
PASS_MSG  = All tests passed

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "RESULT: FAIL, run ended early"; exit 1; fi
	@echo "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
